/* src/vec_pkg.sv */
`default_nettype none

package vec_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned NR_LANES       = 4;
  localparam int unsigned NR_VREGS       = 8;
  localparam int unsigned ELEMS_PER_LANE = 2;
  localparam int unsigned VL             = NR_LANES * ELEMS_PER_LANE;
  localparam int unsigned ELEN           = 16;

  // Index widths
  localparam int unsigned LANE_IDX_W = $clog2(NR_LANES);
  localparam int unsigned SLOT_W     = $clog2(ELEMS_PER_LANE);
  localparam int unsigned VREG_IDX_W = $clog2(NR_VREGS);
  localparam int unsigned ELEM_IDX_W = $clog2(VL);

  // Cycles from the last slot issue until done
  localparam int unsigned DRAIN_CYCLES = 2;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [ELEN-1:0]       elem_t;
  typedef logic [VREG_IDX_W-1:0] vreg_idx_t;
  typedef logic [SLOT_W-1:0]     slot_t;
  typedef logic [ELEM_IDX_W-1:0] elem_idx_t;

  typedef enum logic [2:0] {
    OP_VMV       = 3'd0,
    OP_VADD      = 3'd1,
    OP_VSUB      = 3'd2,
    OP_VXOR      = 3'd3,
    OP_VSLIDE1UP = 3'd4,
    OP_VEXT      = 3'd5
  } vec_op_e;

  // Instruction as issued by the host
  typedef struct packed {
    vec_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_t     scalar;
    elem_idx_t idx;
  } vec_insn_t;

  // Broadcast control word, one slot per cycle
  typedef struct packed {
    logic      valid;
    vec_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    slot_t     slot;
    elem_t     scalar;
    elem_idx_t idx;
  } lane_ctrl_t;

  typedef struct packed {
    elem_t a;
    elem_t b;
  } lane_opnd_t;

endpackage : vec_pkg

`default_nettype wire

/* src/vec_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_sequencer import vec_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  // Host side
  input  logic       insn_valid_i,
  input  vec_insn_t  insn_i,
  // Broadcast to lanes and cross-lane unit
  output lane_ctrl_t ctrl_o,
  output logic       busy_o,
  output logic       done_o,
  output logic       result_valid_o
);

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    DRAIN
  } state_e;

  typedef logic [$clog2(DRAIN_CYCLES)-1:0] drain_cnt_t;

  state_e     state_q;
  vec_insn_t  insn_q;
  slot_t      slot_q;
  drain_cnt_t drain_q;
  lane_ctrl_t ctrl_q;
  logic       busy_q;
  logic       done_q;
  logic       result_valid_q;
  logic       accept;

  // Control word for one slot of an instruction
  function automatic lane_ctrl_t make_ctrl(vec_insn_t insn, slot_t slot);
    lane_ctrl_t ctrl;
    ctrl.valid  = 1'b1;
    ctrl.op     = insn.op;
    ctrl.vd     = insn.vd;
    ctrl.vs1    = insn.vs1;
    ctrl.vs2    = insn.vs2;
    ctrl.slot   = slot;
    ctrl.scalar = insn.scalar;
    ctrl.idx    = insn.idx;
    return ctrl;
  endfunction

  // Strobes while busy are dropped
  assign accept = insn_valid_i && !busy_q;

  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q <= insn_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Issue FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q        <= IDLE;
      slot_q         <= '0;
      drain_q        <= '0;
      ctrl_q         <= '0;
      busy_q         <= 1'b0;
      done_q         <= 1'b0;
      result_valid_q <= 1'b0;
    end else begin
      ctrl_q.valid   <= 1'b0;
      done_q         <= 1'b0;
      result_valid_q <= 1'b0;

      // Busy stays up through the done cycle
      if (done_q) begin
        busy_q <= 1'b0;
      end

      unique case (state_q)
        IDLE: begin
          // Slot 0 goes out straight from the host word
          if (accept) begin
            ctrl_q  <= make_ctrl(insn_i, '0);
            busy_q  <= 1'b1;
            slot_q  <= slot_t'(1);
            state_q <= ISSUE;
          end
        end
        ISSUE: begin
          ctrl_q <= make_ctrl(insn_q, slot_q);
          if (slot_q == slot_t'(ELEMS_PER_LANE - 1)) begin
            drain_q <= '0;
            state_q <= DRAIN;
          end else begin
            slot_q <= slot_q + 1'b1;
          end
        end
        DRAIN: begin
          // Wait for operand read and write-back of the last slot
          if (drain_q == drain_cnt_t'(DRAIN_CYCLES - 1)) begin
            done_q         <= 1'b1;
            result_valid_q <= (insn_q.op == OP_VEXT);
            state_q        <= IDLE;
          end else begin
            drain_q <= drain_q + 1'b1;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  assign ctrl_o         = ctrl_q;
  assign busy_o         = busy_q;
  assign done_o         = done_q;
  assign result_valid_o = result_valid_q;

endmodule : vec_sequencer

`default_nettype wire

/* src/vec_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_lane import vec_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  // From the sequencer
  input  lane_ctrl_t ctrl_i,
  // To and from the cross-lane unit
  output lane_opnd_t opnd_o,
  input  elem_t      slide_elem_i
);

  // This lane's slice of the vector register file
  elem_t      vrf_q [NR_VREGS][ELEMS_PER_LANE];

  lane_opnd_t opnd_q;
  lane_ctrl_t ctrl_q;
  elem_t      alu_res;
  logic       wr_en;

  ////////////////////////////////////////////////////////////////////////////
  // Operand stage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (ctrl_i.valid) begin
      opnd_q.a <= vrf_q[ctrl_i.vs1][ctrl_i.slot];
      opnd_q.b <= vrf_q[ctrl_i.vs2][ctrl_i.slot];
    end
  end

  // Control follows the operands by one cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ctrl_q <= '0;
    end else begin
      ctrl_q <= ctrl_i;
    end
  end

  assign opnd_o = opnd_q;

  ////////////////////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////////////////////

  // Arithmetic wraps at ELEN bits
  always_comb begin
    unique case (ctrl_q.op)
      OP_VMV: begin
        alu_res = ctrl_q.scalar;
      end
      OP_VADD: begin
        alu_res = opnd_q.a + opnd_q.b;
      end
      OP_VSUB: begin
        alu_res = opnd_q.a - opnd_q.b;
      end
      OP_VXOR: begin
        alu_res = opnd_q.a ^ opnd_q.b;
      end
      OP_VSLIDE1UP: begin
        // Neighbour element or carry from the cross-lane unit
        alu_res = slide_elem_i;
      end
      default: begin
        alu_res = opnd_q.a;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Write-back
  ////////////////////////////////////////////////////////////////////////////

  // Extract only reads
  assign wr_en = ctrl_q.valid && (ctrl_q.op != OP_VEXT);

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      vrf_q[ctrl_q.vd][ctrl_q.slot] <= alu_res;
    end
  end

endmodule : vec_lane

`default_nettype wire

/* src/vec_xlane_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_xlane_unit import vec_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // From the sequencer
  input  lane_ctrl_t                ctrl_i,
  // Registered operands of every lane
  input  lane_opnd_t [NR_LANES-1:0] opnd_i,
  output elem_t      [NR_LANES-1:0] slide_elem_o,
  // Extracted element for the host
  output elem_t                     result_data_o
);

  lane_ctrl_t            ctrl_q;
  elem_t                 carry_q;
  elem_t                 result_q;
  logic                  slide_first;
  logic                  slide_step;
  logic                  ext_hit;
  logic [LANE_IDX_W-1:0] ext_lane;
  slot_t                 ext_slot;

  // Aligned with the lanes' operand stage
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ctrl_q <= '0;
    end else begin
      ctrl_q <= ctrl_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Slide-up
  ////////////////////////////////////////////////////////////////////////////

  // Scalar enters one cycle ahead so lane 0 sees it at the slot 0 stage
  assign slide_first = ctrl_i.valid && (ctrl_i.op == OP_VSLIDE1UP) && (ctrl_i.slot == '0);
  assign slide_step  = ctrl_q.valid && (ctrl_q.op == OP_VSLIDE1UP);

  // Carry holds the last lane's element for the next slot
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      carry_q <= '0;
    end else if (slide_first) begin
      carry_q <= ctrl_i.scalar;
    end else if (slide_step) begin
      carry_q <= opnd_i[NR_LANES-1].a;
    end
  end

  always_comb begin
    slide_elem_o[0] = carry_q;
    for (int unsigned k = 1; k < NR_LANES; k++) begin
      slide_elem_o[k] = opnd_i[k-1].a;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Extract
  ////////////////////////////////////////////////////////////////////////////

  // Low index bits pick the lane and the high bits pick the slot
  assign ext_lane = ctrl_q.idx[LANE_IDX_W-1:0];
  assign ext_slot = ctrl_q.idx[ELEM_IDX_W-1:LANE_IDX_W];
  assign ext_hit  = ctrl_q.valid && (ctrl_q.op == OP_VEXT) && (ctrl_q.slot == ext_slot);

  // Held until the next extract
  always_ff @(posedge clk_i) begin
    if (ext_hit) begin
      result_q <= opnd_i[ext_lane].a;
    end
  end

  assign result_data_o = result_q;

endmodule : vec_xlane_unit

`default_nettype wire

/* src/vec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_top import vec_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Host side
  input  logic      insn_valid_i,
  input  vec_insn_t insn_i,
  output logic      busy_o,
  output logic      done_o,
  output logic      result_valid_o,
  output elem_t     result_data_o
);

  lane_ctrl_t                ctrl;
  lane_opnd_t [NR_LANES-1:0] lane_opnd;
  elem_t      [NR_LANES-1:0] slide_elem;

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////////////////////

  vec_sequencer i_sequencer (
    .clk_i         (clk_i         ),
    .rst_n_i       (rst_n_i       ),
    .insn_valid_i  (insn_valid_i  ),
    .insn_i        (insn_i        ),
    .ctrl_o        (ctrl          ),
    .busy_o        (busy_o        ),
    .done_o        (done_o        ),
    .result_valid_o(result_valid_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Lanes
  ////////////////////////////////////////////////////////////////////////////

  // Same control word to every lane
  for (genvar l = 0; l < NR_LANES; l++) begin : gen_lanes
    vec_lane i_lane (
      .clk_i       (clk_i        ),
      .rst_n_i     (rst_n_i      ),
      .ctrl_i      (ctrl         ),
      .opnd_o      (lane_opnd[l] ),
      .slide_elem_i(slide_elem[l])
    );
  end : gen_lanes

  ////////////////////////////////////////////////////////////////////////////
  // Cross-lane unit
  ////////////////////////////////////////////////////////////////////////////

  vec_xlane_unit i_xlane (
    .clk_i        (clk_i        ),
    .rst_n_i      (rst_n_i      ),
    .ctrl_i       (ctrl         ),
    .opnd_i       (lane_opnd    ),
    .slide_elem_o (slide_elem   ),
    .result_data_o(result_data_o)
  );

endmodule : vec_top

`default_nettype wire

/* testbench/tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_checker import vec_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  // DUT ports under watch
  input  logic        insn_valid_i,
  input  vec_insn_t   insn_i,
  input  logic        busy_i,
  input  logic        done_i,
  input  logic        result_valid_i,
  input  elem_t       result_data_i,
  // Totals for the closing line
  output int unsigned check_cnt_o,
  output int unsigned mismatch_cnt_o,
  output int unsigned other_cnt_o,
  output int unsigned accept_cnt_o
);

  // Sampled edges from strobe to done
  localparam int unsigned DONE_DELAY = ELEMS_PER_LANE + 2;

  typedef elem_t [VL-1:0] vec_t;

  vec_t        model_vrf [NR_VREGS];
  vec_insn_t   pend_insn;
  logic        pend = 1'b0;
  int unsigned pend_age = 0;
  elem_t       exp_result = '0;
  logic        have_result = 1'b0;
  int unsigned check_cnt = 0;
  int unsigned mismatch_cnt = 0;
  int unsigned other_cnt = 0;
  int unsigned accept_cnt = 0;

  // New contents of vd with element e at lane e mod 4 and slot e / 4
  function automatic vec_t ref_exec(vec_insn_t insn, vec_t a, vec_t b, vec_t d);
    vec_t r;
    r = d;
    case (insn.op)
      OP_VMV: begin
        for (int e = 0; e < VL; e++) begin
          r[e] = insn.scalar;
        end
      end
      OP_VADD: begin
        for (int e = 0; e < VL; e++) begin
          r[e] = a[e] + b[e];
        end
      end
      OP_VSUB: begin
        for (int e = 0; e < VL; e++) begin
          r[e] = a[e] - b[e];
        end
      end
      OP_VXOR: begin
        for (int e = 0; e < VL; e++) begin
          r[e] = a[e] ^ b[e];
        end
      end
      OP_VSLIDE1UP: begin
        r[0] = insn.scalar;
        for (int e = 1; e < VL; e++) begin
          r[e] = a[e-1];
        end
      end
      default: begin
        r = d;
      end
    endcase
    return r;
  endfunction

  task automatic check_bit(input string name, input logic exp, input logic act);
    check_cnt++;
    if (act !== exp) begin
      mismatch_cnt++;
      $display("mismatch %s: expected %h, actual %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_elem(input string name, input elem_t exp, input elem_t act);
    check_cnt++;
    if (act !== exp) begin
      mismatch_cnt++;
      $display("mismatch %s: expected %h, actual %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic record_insn(input vec_insn_t insn);
    pend      = 1'b1;
    pend_age  = 0;
    pend_insn = insn;
    accept_cnt++;
    if (insn.op == OP_VEXT) begin
      exp_result  = model_vrf[insn.vs1][insn.idx];
      have_result = 1'b1;
    end
    model_vrf[insn.vd] = ref_exec(insn, model_vrf[insn.vs1], model_vrf[insn.vs2],
                                  model_vrf[insn.vd]);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Compare
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (rst_n_i) begin
      if (pend) begin
        pend_age++;
        check_bit("busy_o", 1'b1, busy_i);
        check_bit("done_o", pend_age == DONE_DELAY, done_i);
        check_bit("result_valid_o", (pend_age == DONE_DELAY) && (pend_insn.op == OP_VEXT),
                  result_valid_i);
        if (pend_age == DONE_DELAY) begin
          // Extracted value or the one held from the last vext
          if (have_result) begin
            check_elem("result_data_o", exp_result, result_data_i);
          end
          pend = 1'b0;
        end
      end else begin
        // Idle from reset on and between instructions
        check_bit("busy_o", 1'b0, busy_i);
        check_bit("done_o", 1'b0, done_i);
        check_bit("result_valid_o", 1'b0, result_valid_i);
      end
      if (insn_valid_i) begin
        if (busy_i) begin
          other_cnt++;
          $display("error: instruction strobe while the DUT was busy at %0t", $time);
        end else begin
          record_insn(insn_i);
        end
      end
    end
  end

  assign check_cnt_o    = check_cnt;
  assign mismatch_cnt_o = mismatch_cnt;
  assign other_cnt_o    = other_cnt;
  assign accept_cnt_o   = accept_cnt;

endmodule : tb_checker

`default_nettype wire

/* testbench/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top import vec_pkg::*; ();

  localparam int unsigned N_SLIDE_X = 4;
  localparam int unsigned N_ARITH   = 16;
  // Broadcast, slide fill, slides, arithmetic and three full read-backs
  localparam int unsigned N_INSN = NR_VREGS + NR_VREGS * VL + N_SLIDE_X + N_ARITH
                                   + 3 * NR_VREGS * VL;
  localparam int unsigned TIMEOUT_CYCLES = 6 * N_INSN + 100;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        insn_valid;
  vec_insn_t   insn;
  logic        busy;
  logic        done;
  logic        result_valid;
  elem_t       result_data;
  int          seed = 32'h1e94a700;
  int unsigned issued_cnt = 0;
  int unsigned cycle_cnt = 0;
  int unsigned check_cnt;
  int unsigned mismatch_cnt;
  int unsigned other_cnt;
  int unsigned accept_cnt;

  always #5 clk = ~clk;

  vec_top dut_i (
    .clk_i         (clk         ),
    .rst_n_i       (rst_n       ),
    .insn_valid_i  (insn_valid  ),
    .insn_i        (insn        ),
    .busy_o        (busy        ),
    .done_o        (done        ),
    .result_valid_o(result_valid),
    .result_data_o (result_data )
  );

  tb_checker checker_i (
    .clk_i         (clk         ),
    .rst_n_i       (rst_n       ),
    .insn_valid_i  (insn_valid  ),
    .insn_i        (insn        ),
    .busy_i        (busy        ),
    .done_i        (done        ),
    .result_valid_i(result_valid),
    .result_data_i (result_data ),
    .check_cnt_o   (check_cnt   ),
    .mismatch_cnt_o(mismatch_cnt),
    .other_cnt_o   (other_cnt   ),
    .accept_cnt_o  (accept_cnt  )
  );

  function automatic logic [31:0] next_rand();
    return $random(seed);
  endfunction

  function automatic vec_insn_t make_insn(vec_op_e op, vreg_idx_t vd, vreg_idx_t vs1,
                                          vreg_idx_t vs2, elem_t scalar, elem_idx_t idx);
    vec_insn_t i;
    i.op     = op;
    i.vd     = vd;
    i.vs1    = vs1;
    i.vs2    = vs2;
    i.scalar = scalar;
    i.idx    = idx;
    return i;
  endfunction

  // One-cycle strobe once the DUT is idle
  task automatic issue(input vec_insn_t i);
    @(posedge clk);
    while (busy) begin
      @(posedge clk);
    end
    insn_valid <= 1'b1;
    insn       <= i;
    @(posedge clk);
    insn_valid <= 1'b0;
    issued_cnt++;
  endtask

  task automatic extract_all();
    for (int v = 0; v < NR_VREGS; v++) begin
      for (int e = 0; e < VL; e++) begin
        issue(make_insn(OP_VEXT, '0, vreg_idx_t'(v), '0, '0, elem_idx_t'(e)));
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    vec_op_e     op;
    rst_n      <= 1'b0;
    insn_valid <= 1'b0;
    insn       <= '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    // Broadcast one scalar into every register and read all of it back
    r = next_rand();
    for (int v = 0; v < NR_VREGS; v++) begin
      issue(make_insn(OP_VMV, vreg_idx_t'(v), '0, '0, r[ELEN-1:0], '0));
    end
    extract_all();

    // Fill every register by sliding in random scalars
    for (int v = 0; v < NR_VREGS; v++) begin
      for (int e = 0; e < VL; e++) begin
        r = next_rand();
        issue(make_insn(OP_VSLIDE1UP, vreg_idx_t'(v), vreg_idx_t'(v), '0, r[ELEN-1:0], '0));
      end
    end
    for (int n = 0; n < N_SLIDE_X; n++) begin
      r = next_rand();
      issue(make_insn(OP_VSLIDE1UP, r[2:0], r[5:3], '0, r[31:16], '0));
    end
    extract_all();

    // Random element-wise arithmetic
    for (int n = 0; n < N_ARITH; n++) begin
      r = next_rand();
      case (r[10:9])
        2'd0: op = OP_VADD;
        2'd1: op = OP_VSUB;
        default: op = OP_VXOR;
      endcase
      issue(make_insn(op, r[2:0], r[5:3], r[8:6], '0, '0));
    end
    extract_all();

    @(posedge clk);
    while (busy) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    if (accept_cnt != issued_cnt) begin
      $display("error: %0d instructions issued but %0d accepted", issued_cnt, accept_cnt);
    end
    $display("Checks: %0d, mismatches: %0d, other errors: %0d",
             check_cnt, mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0 && accept_cnt == issued_cnt && check_cnt > 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("error: timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

endmodule : tb_top

`default_nettype wire

/* all.f */
src/vec_pkg.sv
src/vec_sequencer.sv
src/vec_lane.sv
src/vec_xlane_unit.sv
src/vec_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv

/* run.sh */
#!/bin/sh
# Compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_top -f all.f -o tb_top_sim
./obj_dir/tb_top_sim > sim.log 2>&1
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
